//--- source/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and bus address width
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32
`define RV_REG_BITS 5

// address of the first fetch
`define RV_RESET_PC 32'h0000_0000

// instruction word width, pc steps by its byte count
`define RV_ILEN 32

`endif

//--- source/rv_pkg.sv
package rv_pkg;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        st_fetch     = 3'd0,
        st_decode    = 3'd1,
        st_execute   = 3'd2,
        st_memory    = 3'd3,
        st_writeback = 3'd4
    } state_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // lui
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t; // branches too

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t; // jal too

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_u;

endpackage

//--- source/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`RV_REG_BITS-1:0] rs1_idx,
    input  logic [`RV_REG_BITS-1:0] rs2_idx,
    input  logic [`RV_REG_BITS-1:0] rd_idx,
    input  logic                    rd_we,
    input  logic [`RV_XLEN-1:0]     rd_data,
    output logic [`RV_XLEN-1:0]     rs1_data,
    output logic [`RV_XLEN-1:0]     rs2_data
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1]; // x0 has no storage

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // the sequencer filters x0 destinations before asking for a write
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        rd_we |-> rd_idx != '0);

endmodule

//--- source/rv_decode.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_decode import rv_pkg::*; (
    input  instr_u                  instr,
    output opcode_e                 opcode,
    output logic [`RV_REG_BITS-1:0] rd_idx,
    output logic [`RV_REG_BITS-1:0] rs1_idx,
    output logic [`RV_REG_BITS-1:0] rs2_idx,
    output logic [2:0]              funct3,
    output logic [`RV_XLEN-1:0]     imm,
    output alu_op_e                 alu_op,
    output logic                    use_imm,
    output logic                    legal
);

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    logic [6:0]          funct7; // also imm[11:5] of immediate shifts
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

    assign opcode  = opcode_e'(instr.r_fmt.opcode);
    assign rd_idx  = instr.r_fmt.rd;
    assign rs1_idx = instr.r_fmt.rs1;
    assign rs2_idx = instr.r_fmt.rs2;
    assign funct3  = instr.r_fmt.funct3;
    assign funct7  = instr.r_fmt.funct7;

    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_b = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_lo[0],
                    instr.s_fmt.imm_hi[5:0], instr.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_j = {{12{instr.u_fmt.imm[19]}}, instr.u_fmt.imm[7:0], instr.u_fmt.imm[8],
                    instr.u_fmt.imm[18:9], 1'b0};
    assign imm_u = {instr.u_fmt.imm, 12'b0};

    always_comb begin
        imm     = '0;
        alu_op  = alu_add;
        use_imm = 1'b0;
        legal   = 1'b1;
        case (opcode)
            opc_op: begin
                alu_op = arith_op(funct3, funct7[5]);
                legal  = funct7 == 7'b0000000 ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                imm     = imm_i;
                alu_op  = arith_op(funct3, funct3 == 3'b101 && funct7[5]); // no subi
                if (funct3 == 3'b001) begin
                    legal = funct7 == 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                end
            end
            opc_load: begin
                imm   = imm_i;
                legal = funct3 == 3'b010; // lw only
            end
            opc_store: begin
                imm   = imm_s;
                legal = funct3 == 3'b010; // sw only
            end
            opc_branch: begin
                imm   = imm_b;
                legal = funct3[2:1] != 2'b01;
            end
            opc_jal: imm = imm_j;
            opc_lui: begin
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = alu_pass_b;
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

//--- source/rv_alu.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  alu_op_e             alu_op,
    input  logic [2:0]          funct3,
    output logic [`RV_XLEN-1:0] result,
    output logic                take_branch
);

    logic [4:0] shamt;
    logic       eq, lt_s, lt_u; // shared by slt and branches

    assign shamt = b[4:0];
    assign eq    = a == b;
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  take_branch = eq;    // beq
            3'b001:  take_branch = !eq;   // bne
            3'b100:  take_branch = lt_s;  // blt
            3'b101:  take_branch = !lt_s; // bge
            3'b110:  take_branch = lt_u;  // bltu
            3'b111:  take_branch = !lt_u; // bgeu
            default: take_branch = 1'b0;
        endcase
    end

endmodule

//--- source/rv_control.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_control import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_ack,
    input  logic [`RV_XLEN-1:0]     wb_rdata,
    input  opcode_e                 opcode,
    input  logic [`RV_REG_BITS-1:0] rd_idx,
    input  logic                    use_imm,
    input  logic [`RV_XLEN-1:0]     imm,
    input  logic                    legal,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    input  logic [`RV_XLEN-1:0]     alu_result,
    input  logic                    take_branch,
    output instr_u                  instr,
    output logic [`RV_XLEN-1:0]     alu_a,
    output logic [`RV_XLEN-1:0]     alu_b,
    output logic                    rf_we,
    output logic [`RV_REG_BITS-1:0] rf_rd_idx,
    output logic [`RV_XLEN-1:0]     rf_rd_data,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`RV_XLEN-1:0]     wb_adr,
    output logic [`RV_XLEN-1:0]     wb_wdata
);

    localparam logic [`RV_XLEN-1:0] pc_step = `RV_ILEN / 8;

    state_e              state;
    logic [`RV_XLEN-1:0] pc, pc_next, result_q;
    logic [`RV_XLEN-1:0] pc_plus4, pc_target, ls_addr;
    logic                is_mem, is_store, writes_rd, redirect;

    assign pc_plus4  = pc + pc_step; // also the jal link value
    assign pc_target = pc + imm;
    assign ls_addr   = rs1_data + imm;
    assign is_store  = legal && opcode == opc_store;
    assign is_mem    = is_store || (legal && opcode == opc_load);
    assign writes_rd = legal && opcode != opc_store && opcode != opc_branch;
    assign redirect  = opcode == opc_jal || (legal && opcode == opc_branch && take_branch);

    assign alu_a      = rs1_data;
    assign alu_b      = use_imm ? imm : rs2_data;
    assign rf_we      = state == st_writeback && writes_rd && rd_idx != '0;
    assign rf_rd_idx  = rd_idx;
    assign rf_rd_data = result_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_fetch;
            pc     <= `RV_RESET_PC;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!wb_cyc) begin // only right after reset
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= st_decode;
                    end
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    if (is_mem) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= is_store;
                    end
                    state <= st_memory;
                end
                st_memory: begin
                    if (!wb_cyc) begin
                        state <= st_writeback;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        state  <= st_writeback;
                    end
                end
                st_writeback: begin
                    pc     <= pc_next;
                    wb_cyc <= 1'b1; // next fetch goes out with the pc update
                    wb_stb <= 1'b1;
                    state  <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_fetch: begin
                if (!wb_cyc) begin
                    wb_adr <= pc;
                end else if (wb_ack) begin
                    instr <= wb_rdata;
                end
            end
            st_execute: begin
                wb_adr   <= ls_addr;
                wb_wdata <= rs2_data;
                result_q <= (opcode == opc_jal) ? pc_plus4 : alu_result;
                pc_next  <= redirect ? pc_target : pc_plus4;
            end
            st_memory: begin
                if (wb_cyc && wb_ack && !wb_we) begin
                    result_q <= wb_rdata; // lw data
                end
            end
            st_writeback: wb_adr <= pc_next;
            default: ;
        endcase
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

    a_we_store_only: assert property (@(posedge clk) disable iff (rst)
        wb_we |-> (state == st_memory && opcode == opc_store));

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {st_fetch, st_decode, st_execute, st_memory, st_writeback});

endmodule

//--- source/rv_core.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_ack,
    input  logic [`RV_XLEN-1:0] wb_rdata,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`RV_XLEN-1:0] wb_adr,
    output logic [`RV_XLEN-1:0] wb_wdata
);

    instr_u                  instr;
    opcode_e                 opcode;
    alu_op_e                 alu_op;
    logic [`RV_REG_BITS-1:0] rd_idx, rs1_idx, rs2_idx, rf_rd_idx;
    logic [2:0]              funct3;
    logic [`RV_XLEN-1:0]     imm, rs1_data, rs2_data, alu_a, alu_b, alu_result, rf_rd_data;
    logic                    use_imm, legal, take_branch, rf_we;

    rv_control u_control (
        .clk(clk), .rst(rst),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata),
        .opcode(opcode), .rd_idx(rd_idx), .use_imm(use_imm), .imm(imm), .legal(legal),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_result(alu_result), .take_branch(take_branch),
        .instr(instr), .alu_a(alu_a), .alu_b(alu_b),
        .rf_we(rf_we), .rf_rd_idx(rf_rd_idx), .rf_rd_data(rf_rd_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rf_rd_idx),
        .rd_we(rf_we), .rd_data(rf_rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_decode u_decode (
        .instr(instr), .opcode(opcode),
        .rd_idx(rd_idx), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .funct3(funct3), .imm(imm), .alu_op(alu_op), .use_imm(use_imm), .legal(legal)
    );

    rv_alu u_alu (
        .a(alu_a), .b(alu_b), .alu_op(alu_op), .funct3(funct3),
        .result(alu_result), .take_branch(take_branch)
    );

endmodule

//--- tests/rv_clock_gen.sv
`timescale 1ns/100ps

module rv_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0; // released just after the edge
    end

endmodule

//--- tests/rv_core_tb.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int alu_pairs   = 3;
    localparam int alu_instrs  = alu_pairs * 42 + 1;
    localparam int cycle_limit = 8 * (4 + 3 + 3) * (2 * alu_instrs + 85 + 7);
    localparam logic [29:0] r_f3  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    localparam logic [9:0]  r_alt = 10'b0010000010; // sub, sra
    localparam logic [26:0] i_f3  = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};

    logic                clk, rst, rst_por, test_rst;
    logic                wb_ack, wb_cyc, wb_stb, wb_we;
    logic [`RV_XLEN-1:0] wb_rdata, wb_adr, wb_wdata;

    logic [31:0] mem [int unsigned]; // word addressed
    logic [31:0] exp_adr [$];
    logic [31:0] exp_data [$];
    logic [31:0] op_a [alu_pairs];
    logic [31:0] op_b [alu_pairs];
    logic [11:0] op_imm [alu_pairs][9];
    logic [31:0] hold_adr, hold_wdata;
    logic        hold_we, busy;
    int          wait_left, prog_len, cycle_count;
    int          mismatches = 0;
    int          timeouts = 0;
    int          seed = 61;
    bit          random_waits;

    assign rst = rst_por | test_rst;

    rv_clock_gen u_clock_gen (.clk(clk), .rst(rst_por));

    rv_core u_rv_core (
        .clk(clk), .rst(rst),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, opc_lui};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ({32{alt & a[31]}} & ~(32'hffff_ffff >> sh));
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        logic signed_lt;
        signed_lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // biased compare
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return signed_lt;
            3'd5:    return !signed_lt;
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [63:0] branch_operands(input int c);
        case (c)
            0:       return {32'd5, 32'd5};
            1:       return {32'd5, 32'd6};
            2:       return {32'd7, 32'd7};
            3:       return {32'h8000_0000, 32'd0};
            4:       return {32'h8000_0000, 32'd1}; // signed vs unsigned edge
            5:       return {32'd1, 32'h8000_0000};
            6:       return {32'hffff_ffff, 32'd0};
            7:       return {32'd0, 32'hffff_ffff};
            8:       return {32'h8000_0000, 32'd1};
            9:       return {32'd1, 32'hffff_ffff};
            10:      return {32'hffff_ffff, 32'd0};
            default: return {32'd0, 32'd1};
        endcase
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_held_request();
        expect_value("wb_adr", wb_adr, hold_adr);
        expect_value("wb_we", wb_we, hold_we);
        expect_value("wb_wdata", wb_wdata, hold_wdata);
    endtask

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic start_program();
        mem.delete();
        exp_adr.delete();
        exp_data.delete();
        prog_len = 0;
    endtask

    task automatic load_operand(input logic [4:0] rd, input logic [11:0] adr,
                                input logic [31:0] value);
        mem[adr >> 2] = value;
        emit(i_type(adr, 5'd0, 3'b010, rd, opc_load));
    endtask

    task automatic store_result(input logic [4:0] rs, input logic [31:0] expected);
        logic [11:0] slot;
        slot = 12'h700 + 12'(4 * exp_adr.size());
        emit({slot[11:5], rs, 5'd0, 3'b010, slot[4:0], opc_store}); // sw rs, slot(x0)
        exp_adr.push_back(32'(slot));
        exp_data.push_back(expected);
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1 test_rst = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            expect_value("wb_cyc", wb_cyc, 1'b0);
            expect_value("wb_stb", wb_stb, 1'b0);
            expect_value("wb_we", wb_we, 1'b0);
        end
        test_rst = 1'b0;
        @(posedge clk);
        #1;
        expect_value("wb_cyc", wb_cyc, 1'b1); // first fetch right after release
        expect_value("wb_stb", wb_stb, 1'b1);
        expect_value("wb_we", wb_we, 1'b0);
        expect_value("wb_adr", wb_adr, `RV_RESET_PC);
    endtask

    task automatic run_program();
        logic [31:0] halt_adr;
        logic [31:0] got;
        halt_adr = 4 * prog_len;
        emit(j_type(5'd0, 21'd0)); // jal x0, 0
        reset_core();
        while (!(wb_cyc === 1'b1 && wb_stb === 1'b1 && wb_we === 1'b0
                 && wb_adr === halt_adr)) begin
            @(posedge clk);
            #1;
        end
        foreach (exp_adr[i]) begin
            got = mem.exists(exp_adr[i] >> 2) ? mem[exp_adr[i] >> 2] : 'x;
            expect_value($sformatf("mem[%h]", exp_adr[i]), got, exp_data[i]);
        end
    endtask

    task automatic pick_operands();
        for (int p = 0; p < alu_pairs; p++) begin
            op_a[p] = $random(seed);
            op_b[p] = $random(seed);
            for (int k = 0; k < 9; k++) begin
                op_imm[p][k] = $random(seed);
            end
        end
    endtask

    task automatic alu_test(input bit waits_on);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        random_waits = waits_on;
        start_program();
        for (int p = 0; p < alu_pairs; p++) begin
            load_operand(5'd1, 12'h600 + 12'(8 * p), op_a[p]);
            load_operand(5'd2, 12'h604 + 12'(8 * p), op_b[p]);
            for (int k = 0; k < 10; k++) begin
                f3  = r_f3[3*k +: 3];
                alt = r_alt[k];
                emit(r_type({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'd3));
                store_result(5'd3, alu_ref(f3, alt, op_a[p], op_b[p]));
            end
            for (int k = 0; k < 9; k++) begin
                f3  = i_f3[3*k +: 3];
                alt = k == 8; // srai
                imm = op_imm[p][k];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, alt, 5'd0, op_imm[p][k][4:0]};
                end
                emit(i_type(imm, 5'd1, f3, 5'd3, opc_op_imm));
                store_result(5'd3, alu_ref(f3, alt, op_a[p], {{20{imm[11]}}, imm}));
            end
            emit(r_type(7'd0, 5'd2, 5'd1, 3'd0, 5'd0)); // add into x0
            store_result(5'd0, '0);
        end
        run_program();
    endtask

    task automatic branch_test();
        logic [63:0] ab;
        logic [2:0]  f3;
        random_waits = 1'b0;
        start_program();
        for (int c = 0; c < 12; c++) begin
            ab = branch_operands(c);
            f3 = (c / 2 < 2) ? 3'(c / 2) : 3'(c / 2 + 2);
            load_operand(5'd1, 12'h600 + 12'(8 * c), ab[63:32]);
            load_operand(5'd2, 12'h604 + 12'(8 * c), ab[31:0]);
            emit(b_type(f3, 5'd1, 5'd2, 13'd12));
            emit(i_type(12'h200 + 12'(c), 5'd0, 3'd0, 5'd3, opc_op_imm)); // not taken marker
            emit(j_type(5'd0, 21'd8));
            emit(i_type(12'h100 + 12'(c), 5'd0, 3'd0, 5'd3, opc_op_imm)); // taken marker
            store_result(5'd3, branch_ref(f3, ab[63:32], ab[31:0]) ? 32'h100 + c : 32'h200 + c);
        end
        run_program();
    endtask

    task automatic jump_test();
        logic [31:0] link;
        random_waits = 1'b0;
        start_program();
        emit(u_type(5'd7, 20'habcde));
        store_result(5'd7, {20'habcde, 12'h000});
        link = 4 * prog_len + 4;
        emit(j_type(5'd5, 21'd8));
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd6, opc_op_imm)); // skipped
        store_result(5'd5, link);
        store_result(5'd6, '0);
        run_program();
    endtask

    // wishbone slave, samples at the edge and answers 1 ns later
    initial begin : bus_slave
        forever begin
            @(posedge clk);
            if (rst || wb_ack) begin
                if (!rst) begin
                    compare_held_request(); // the ack cycle still carries the request
                end
                busy = 1'b0;
                #1 wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy       = 1'b1;
                    hold_adr   = wb_adr;
                    hold_we    = wb_we;
                    hold_wdata = wb_wdata;
                    wait_left  = random_waits ? $unsigned($random(seed)) % 4 : 0;
                end else begin
                    compare_held_request(); // held until ack
                end
                #1;
                if (wait_left > 0) begin
                    wait_left--;
                end else if (hold_we) begin
                    mem[hold_adr >> 2] = hold_wdata;
                    wb_ack = 1'b1;
                end else begin
                    wb_rdata = mem.exists(hold_adr >> 2) ? mem[hold_adr >> 2] : '0;
                    wb_ack   = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        timeouts++;
        $display("timeout: no halt loop reached within %0d cycles", cycle_limit);
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        test_rst     = 1'b0;
        wb_ack       = 1'b0;
        wb_rdata     = '0;
        busy         = 1'b0;
        random_waits = 1'b0;
        @(negedge rst_por);
        pick_operands();
        alu_test(1'b0);
        branch_test();
        jump_test();
        alu_test(1'b1); // same program with slave wait states
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_control.sv
source/rv_core.sv
tests/rv_clock_gen.sv
tests/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - source/rv_pkg.sv
  - source/rv_regfile.sv
  - source/rv_decode.sv
  - source/rv_alu.sv
  - source/rv_control.sv
  - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/rv_clock_gen.sv
      - tests/rv_core_tb.sv
